// ==== logic/cpu_pkg.sv ====
// cpu shared definitions
// widths, opcodes and control codes

package cpu_pkg;

    // ------------------------------
    // isa widths
    // ------------------------------
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 2 ** REG_ADDR_W;  // register file depth
    localparam int OPCODE_W   = 6;
    localparam int IMM_W      = 16;               // immediate field width

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ------------------------------
    // opcodes
    // ------------------------------
    // any value not listed here is a no-operation
    typedef enum logic [OPCODE_W-1:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLT  = 6'h06,  // signed set-less-than
        OP_ADDI = 6'h07,
        OP_ORI  = 6'h08,  // zero-extended immediate
        OP_LUI  = 6'h09,
        OP_LD   = 6'h0a,
        OP_ST   = 6'h0b,
        OP_BEQ  = 6'h0c,
        OP_BNE  = 6'h0d
    } opcode_t;

    // ------------------------------
    // execute control codes
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        CMP_NOP = 2'd0,
        CMP_EQ  = 2'd1,
        CMP_NE  = 2'd2,
        CMP_LT  = 2'd3   // signed
    } cmp_op_t;

    typedef enum logic [1:0] {
        MEM_NOP = 2'd0,
        MEM_LD  = 2'd1,
        MEM_ST  = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        OUT_ALU = 2'd0,
        OUT_CMP = 2'd1,
        OUT_ID  = 2'd2   // value computed in decode
    } out_sel_t;

endpackage

// ==== logic/gpr_file.sv ====
// general purpose register file

`timescale 1ns/1ns

module gpr_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // read ports
    input  reg_addr_t ra_addr,
    input  reg_addr_t rb_addr,
    output word_t     ra_data,
    output word_t     rb_data,
    // write port
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [REG_NUM];

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin  // r0 is never written
            regs[wr_addr] <= wr_data;
        end
    end

    // ------------------------------
    // read ports
    // ------------------------------
    // no bypass of a write in the same cycle
    assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
    assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

// ==== logic/id_decoder.sv ====
// instruction decoder with forwarding

`timescale 1ns/1ns

module id_decoder
    import cpu_pkg::*;
(
    input  logic      if_en,
    input  word_t     insn,
    // register file
    output reg_addr_t ra_addr,
    output reg_addr_t rb_addr,
    input  word_t     ra_data,
    input  word_t     rb_data,
    // forwarding from ex
    input  logic      fwd_en,
    input  reg_addr_t fwd_addr,
    input  word_t     fwd_data,
    // decode fields
    output logic      en,
    output alu_op_t   alu_op,
    output word_t     alu_in_0,
    output word_t     alu_in_1,
    output cmp_op_t   cmp_op,
    output word_t     cmp_in_0,
    output word_t     cmp_in_1,
    output mem_op_t   mem_op,
    output word_t     mem_wr_data,
    output reg_addr_t dst_addr,
    output logic      gpr_we,
    output out_sel_t  out_sel,
    output word_t     gpr_wr_data
);

    opcode_t           opcode;
    reg_addr_t         rd_addr;
    logic [IMM_W-1:0]  imm16;
    word_t             imm_s;
    word_t             imm_u;
    word_t             ra_val;
    word_t             rb_val;

    // ------------------------------
    // field split
    // ------------------------------
    assign opcode  = opcode_t'(insn[31:26]);
    assign ra_addr = insn[25:21];
    assign rb_addr = insn[20:16];
    assign rd_addr = insn[15:11];  // r-type destination
    assign imm16   = insn[IMM_W-1:0];
    assign imm_s   = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign imm_u   = {{(WORD_W-IMM_W){1'b0}}, imm16};

    // forwarded ex result wins over the register file
    assign ra_val = (fwd_en && fwd_addr != '0 && fwd_addr == ra_addr) ? fwd_data : ra_data;
    assign rb_val = (fwd_en && fwd_addr != '0 && fwd_addr == rb_addr) ? fwd_data : rb_data;

    assign en = if_en;

    // ------------------------------
    // control decode
    // ------------------------------
    always_comb begin
        alu_op      = ALU_NOP;
        alu_in_0    = ra_val;
        alu_in_1    = rb_val;
        cmp_op      = CMP_NOP;
        cmp_in_0    = ra_val;
        cmp_in_1    = rb_val;
        mem_op      = MEM_NOP;
        mem_wr_data = '0;
        dst_addr    = rd_addr;
        gpr_we      = 1'b0;
        out_sel     = OUT_ALU;
        gpr_wr_data = '0;

        case (opcode)
            OP_ADD: begin alu_op = ALU_ADD; gpr_we = 1'b1; end
            OP_SUB: begin alu_op = ALU_SUB; gpr_we = 1'b1; end
            OP_AND: begin alu_op = ALU_AND; gpr_we = 1'b1; end
            OP_OR:  begin alu_op = ALU_OR;  gpr_we = 1'b1; end
            OP_XOR: begin alu_op = ALU_XOR; gpr_we = 1'b1; end
            OP_SLT: begin
                cmp_op  = CMP_LT;
                out_sel = OUT_CMP;   // 0 or 1
                gpr_we  = 1'b1;
            end
            OP_ADDI, OP_ORI: begin
                alu_op   = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
                alu_in_1 = (opcode == OP_ORI) ? imm_u : imm_s;
                dst_addr = rb_addr;  // i-type destination
                gpr_we   = 1'b1;
            end
            OP_LUI: begin
                gpr_wr_data = {imm16, {(WORD_W-IMM_W){1'b0}}};
                out_sel     = OUT_ID;
                dst_addr    = rb_addr;
                gpr_we      = 1'b1;
            end
            OP_LD, OP_ST: begin
                alu_op   = ALU_ADD;  // address = ra + imm
                alu_in_1 = imm_s;
                dst_addr = rb_addr;
                if (opcode == OP_LD) begin
                    mem_op = MEM_LD;
                    gpr_we = 1'b1;
                end else begin
                    mem_op      = MEM_ST;
                    mem_wr_data = rb_val;
                end
            end
            OP_BEQ, OP_BNE: begin
                cmp_op   = (opcode == OP_BEQ) ? CMP_EQ : CMP_NE;
                alu_op   = ALU_ADD;  // target = 0 + imm
                alu_in_0 = '0;
                alu_in_1 = imm_s;
            end
            default: begin
                gpr_we = 1'b0;       // unknown opcode
            end
        endcase

        // nothing leaves decode without a valid instruction
        if (!if_en) begin
            gpr_we = 1'b0;
            mem_op = MEM_NOP;
        end
    end

endmodule

// ==== logic/pipe_ctrl.sv ====
// id/ex pipeline control

`timescale 1ns/1ns

module pipe_ctrl
    import cpu_pkg::*;
(
    input  logic      stall,
    // sources of the instruction in decode
    input  reg_addr_t ra_addr,
    input  reg_addr_t rb_addr,
    // instruction in execute
    input  logic      ex_en,
    input  logic      ex_gpr_we,
    input  reg_addr_t ex_dst_addr,
    input  mem_op_t   ex_mem_op,
    input  logic      branch_taken,
    // controls
    output logic      id_stall,
    output logic      id_flush,
    output logic      if_stall
);

    logic ex_load;
    logic load_use;

    // ------------------------------
    // load-use hazard
    // ------------------------------
    // a load result is not forwarded, so decode waits one cycle
    assign ex_load  = ex_en && ex_gpr_we && (ex_mem_op == MEM_LD) && (ex_dst_addr != '0);
    assign load_use = ex_load && ((ex_dst_addr == ra_addr) || (ex_dst_addr == rb_addr));

    assign id_stall = stall;
    assign id_flush = branch_taken || load_use;  // bubble into ex
    assign if_stall = stall || load_use;         // fetch holds its word

endmodule

// ==== logic/id_reg.sv ====
// id/ex stage register

`timescale 1ns/1ns

module id_reg
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      flush,
    // decode fields
    input  logic      if_en,
    input  alu_op_t   alu_op,
    input  word_t     alu_in_0,
    input  word_t     alu_in_1,
    input  cmp_op_t   cmp_op,
    input  word_t     cmp_in_0,
    input  word_t     cmp_in_1,
    input  mem_op_t   mem_op,
    input  word_t     mem_wr_data,
    input  reg_addr_t dst_addr,
    input  logic      gpr_we,
    input  out_sel_t  out_sel,
    input  word_t     gpr_wr_data,
    // registered fields
    output logic      id_en,
    output alu_op_t   id_alu_op,
    output word_t     id_alu_in_0,
    output word_t     id_alu_in_1,
    output cmp_op_t   id_cmp_op,
    output word_t     id_cmp_in_0,
    output word_t     id_cmp_in_1,
    output mem_op_t   id_mem_op,
    output word_t     id_mem_wr_data,
    output reg_addr_t id_dst_addr,
    output logic      id_gpr_we,
    output out_sel_t  id_out_sel,
    output word_t     id_gpr_wr_data
);

    // stall holds, flush clears, otherwise load
    always_ff @(posedge clk) begin
        if (!rst_n || (!stall && flush)) begin
            id_en          <= 1'b0;          // becomes a nop
            id_alu_op      <= ALU_NOP;
            id_alu_in_0    <= '0;
            id_alu_in_1    <= '0;
            id_cmp_op      <= CMP_NOP;
            id_cmp_in_0    <= '0;
            id_cmp_in_1    <= '0;
            id_mem_op      <= MEM_NOP;
            id_mem_wr_data <= '0;
            id_dst_addr    <= '0;
            id_gpr_we      <= 1'b0;
            id_out_sel     <= OUT_ALU;
            id_gpr_wr_data <= '0;
        end else if (!stall) begin
            id_en          <= if_en;
            id_alu_op      <= alu_op;
            id_alu_in_0    <= alu_in_0;
            id_alu_in_1    <= alu_in_1;
            id_cmp_op      <= cmp_op;
            id_cmp_in_0    <= cmp_in_0;
            id_cmp_in_1    <= cmp_in_1;
            id_mem_op      <= mem_op;
            id_mem_wr_data <= mem_wr_data;
            id_dst_addr    <= dst_addr;
            id_gpr_we      <= gpr_we;
            id_out_sel     <= out_sel;
            id_gpr_wr_data <= gpr_wr_data;
        end
    end

endmodule

// ==== logic/ex_stage.sv ====
// execute stage
// alu, comparator and branch decision

`timescale 1ns/1ns

module ex_stage
    import cpu_pkg::*;
(
    input  logic     id_en,
    input  alu_op_t  id_alu_op,
    input  word_t    id_alu_in_0,
    input  word_t    id_alu_in_1,
    input  cmp_op_t  id_cmp_op,
    input  word_t    id_cmp_in_0,
    input  word_t    id_cmp_in_1,
    input  out_sel_t id_out_sel,
    input  word_t    id_gpr_wr_data,
    output word_t    ex_out,
    output logic     branch_taken,
    output word_t    branch_target
);

    word_t alu_out;
    logic  cmp_out;
    logic  is_branch;

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (id_alu_op)
            ALU_ADD: alu_out = id_alu_in_0 + id_alu_in_1;
            ALU_SUB: alu_out = id_alu_in_0 - id_alu_in_1;
            ALU_AND: alu_out = id_alu_in_0 & id_alu_in_1;
            ALU_OR:  alu_out = id_alu_in_0 | id_alu_in_1;
            ALU_XOR: alu_out = id_alu_in_0 ^ id_alu_in_1;
            default: alu_out = '0;
        endcase
    end

    // ------------------------------
    // comparator
    // ------------------------------
    always_comb begin
        case (id_cmp_op)
            CMP_EQ:  cmp_out = (id_cmp_in_0 == id_cmp_in_1);
            CMP_NE:  cmp_out = (id_cmp_in_0 != id_cmp_in_1);
            CMP_LT:  cmp_out = ($signed(id_cmp_in_0) < $signed(id_cmp_in_1));
            default: cmp_out = 1'b0;
        endcase
    end

    // ------------------------------
    // result select
    // ------------------------------
    always_comb begin
        case (id_out_sel)
            OUT_CMP: ex_out = {{(WORD_W-1){1'b0}}, cmp_out};
            OUT_ID:  ex_out = id_gpr_wr_data;  // e.g. lui
            default: ex_out = alu_out;
        endcase
    end

    // only eq and ne compares steer the pc
    assign is_branch     = (id_cmp_op == CMP_EQ) || (id_cmp_op == CMP_NE);
    assign branch_taken  = id_en && is_branch && cmp_out;
    assign branch_target = alu_out;  // 0 + imm from decode

endmodule

// ==== logic/cpu_id_ex.sv ====
// decode and execute slice top level

`timescale 1ns/1ns

module cpu_id_ex
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // fetch
    input  logic      if_en,
    input  word_t     if_insn,
    input  logic      stall,
    output logic      if_stall,
    // writeback
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    // execute
    output logic      ex_en,
    output word_t     ex_out,
    output reg_addr_t ex_dst_addr,
    output logic      ex_gpr_we,
    output mem_op_t   ex_mem_op,
    output word_t     ex_mem_wr_data,
    output logic      branch_taken,
    output word_t     branch_target
);

    reg_addr_t ra_addr, rb_addr;
    word_t     ra_data, rb_data;
    logic      id_stall, id_flush;

    // decode fields
    logic      dec_en, dec_gpr_we;
    alu_op_t   dec_alu_op;
    cmp_op_t   dec_cmp_op;
    mem_op_t   dec_mem_op;
    out_sel_t  dec_out_sel;
    reg_addr_t dec_dst_addr;
    word_t     dec_alu_in_0, dec_alu_in_1, dec_cmp_in_0, dec_cmp_in_1;
    word_t     dec_mem_wr_data, dec_gpr_wr_data;

    // id/ex register outputs feeding execute
    alu_op_t   id_alu_op;
    cmp_op_t   id_cmp_op;
    out_sel_t  id_out_sel;
    word_t     id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1, id_gpr_wr_data;

    // loads are not forwarded, pipe_ctrl stalls them instead
    wire fwd_en = ex_en && ex_gpr_we && (ex_mem_op != MEM_LD);

    gpr_file gpr_file_i (
        .clk, .rst_n, .ra_addr, .rb_addr, .ra_data, .rb_data,
        .we(wb_we), .wr_addr(wb_addr), .wr_data(wb_data)
    );

    id_decoder id_decoder_i (
        .if_en, .insn(if_insn), .ra_addr, .rb_addr, .ra_data, .rb_data,
        .fwd_en, .fwd_addr(ex_dst_addr), .fwd_data(ex_out),
        .en(dec_en), .alu_op(dec_alu_op), .alu_in_0(dec_alu_in_0), .alu_in_1(dec_alu_in_1),
        .cmp_op(dec_cmp_op), .cmp_in_0(dec_cmp_in_0), .cmp_in_1(dec_cmp_in_1),
        .mem_op(dec_mem_op), .mem_wr_data(dec_mem_wr_data), .dst_addr(dec_dst_addr),
        .gpr_we(dec_gpr_we), .out_sel(dec_out_sel), .gpr_wr_data(dec_gpr_wr_data)
    );

    pipe_ctrl pipe_ctrl_i (
        .stall, .ra_addr, .rb_addr, .ex_en, .ex_gpr_we, .ex_dst_addr, .ex_mem_op,
        .branch_taken, .id_stall, .id_flush, .if_stall
    );

    id_reg id_reg_i (
        .clk, .rst_n, .stall(id_stall), .flush(id_flush),
        .if_en(dec_en), .alu_op(dec_alu_op), .alu_in_0(dec_alu_in_0), .alu_in_1(dec_alu_in_1),
        .cmp_op(dec_cmp_op), .cmp_in_0(dec_cmp_in_0), .cmp_in_1(dec_cmp_in_1),
        .mem_op(dec_mem_op), .mem_wr_data(dec_mem_wr_data), .dst_addr(dec_dst_addr),
        .gpr_we(dec_gpr_we), .out_sel(dec_out_sel), .gpr_wr_data(dec_gpr_wr_data),
        .id_en(ex_en), .id_alu_op, .id_alu_in_0, .id_alu_in_1,
        .id_cmp_op, .id_cmp_in_0, .id_cmp_in_1,
        .id_mem_op(ex_mem_op), .id_mem_wr_data(ex_mem_wr_data), .id_dst_addr(ex_dst_addr),
        .id_gpr_we(ex_gpr_we), .id_out_sel, .id_gpr_wr_data
    );

    ex_stage ex_stage_i (
        .id_en(ex_en), .id_alu_op, .id_alu_in_0, .id_alu_in_1,
        .id_cmp_op, .id_cmp_in_0, .id_cmp_in_1, .id_out_sel, .id_gpr_wr_data,
        .ex_out, .branch_taken, .branch_target
    );

endmodule

// ==== testbench/id_ex_checker.sv ====
// id/ex output checker

`timescale 1ns/1ns

module id_ex_checker
    import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         live,     // a table row is driven
    input  logic         first,
    input  logic         stall,
    input  logic [127:0] name,
    input  logic         exp_en,
    input  word_t        exp_out,
    input  reg_addr_t    exp_dst,
    input  logic         exp_we,
    input  mem_op_t      exp_mem,
    input  word_t        exp_wdat,
    input  logic         exp_br,
    input  logic         exp_ifs,
    input  logic         if_stall,
    input  logic         ex_en,
    input  word_t        ex_out,
    input  reg_addr_t    ex_dst_addr,
    input  logic         ex_gpr_we,
    input  mem_op_t      ex_mem_op,
    input  word_t        ex_mem_wr_data,
    input  logic         branch_taken,
    input  word_t        branch_target,
    output int           err_cnt
);

    logic         pend;        // row accepted last cycle
    logic         bubble;      // hazard hold last cycle
    logic [127:0] p_name;
    logic         p_en, p_we, p_br;
    word_t        p_out;
    word_t        p_wdat;
    reg_addr_t    p_dst;
    mem_op_t      p_mem;

    initial err_cnt = 0;

    task automatic check_val(input logic [127:0] tname, input string field, input word_t exp,
                             input word_t act);
        if (exp !== act) begin
            $display("Error %0s %0s: expected %h, actual %h", tname, field, exp, act);
            err_cnt++;
        end
    endtask

    // ------------------------------
    // compare on the falling edge
    // ------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            pend   <= 1'b0;
            bubble <= 1'b0;
        end else begin
            if (pend) begin
                check_val(p_name, "ex_en", p_en, ex_en);
                check_val(p_name, "ex_out", p_out, ex_out);
                check_val(p_name, "ex_dst_addr", p_dst, ex_dst_addr);
                check_val(p_name, "ex_gpr_we", p_we, ex_gpr_we);
                check_val(p_name, "ex_mem_op", p_mem, ex_mem_op);
                check_val(p_name, "ex_mem_wr_data", p_wdat, ex_mem_wr_data);
                check_val(p_name, "branch_taken", p_br, branch_taken);
                if (p_br) begin
                    check_val(p_name, "branch_target", p_out, branch_target);
                end
            end
            if (bubble) begin
                check_val(p_name, "bubble ex_en", '0, ex_en);
            end
            if (live && first) begin
                check_val(name, "if_stall", exp_ifs, if_stall);
            end
            pend   <= live && !(if_stall && !stall);
            bubble <= live && if_stall && !stall;
            p_name <= name;
            p_en   <= exp_en;
            p_out  <= exp_out;
            p_dst  <= exp_dst;
            p_we   <= exp_we;
            p_mem  <= exp_mem;
            p_wdat <= exp_wdat;
            p_br   <= exp_br;
        end
    end

endmodule

// ==== testbench/cpu_id_ex_props.sv ====
// control timing assertions

`timescale 1ns/1ns

module cpu_id_ex_props
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input logic      if_stall,
    input logic      ex_en,
    input word_t     ex_out,
    input reg_addr_t ex_dst_addr,
    input logic      ex_gpr_we,
    input mem_op_t   ex_mem_op,
    input logic      branch_taken
);

    int fail_cnt = 0;

    // quiet pipeline right after reset
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |->
        !if_stall && !branch_taken && !ex_en && ex_mem_op == MEM_NOP)
        else begin
            $error("control outputs not idle after reset");
            fail_cnt++;
        end

    // squashed slot behind a taken branch
    branch_squash: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken && !stall |=> !ex_en)
        else begin
            $error("ex_en still high in the cycle after a taken branch");
            fail_cnt++;
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(ex_en) && $stable(ex_out) && $stable(ex_dst_addr)
                  && $stable(ex_gpr_we) && $stable(ex_mem_op))
        else begin
            $error("execute outputs changed during stall");
            fail_cnt++;
        end

endmodule

// ==== testbench/tb_cpu_id_ex.sv ====
// decode and execute slice testbench

`timescale 1ns/1ns

module tb_cpu_id_ex
    import cpu_pkg::*;
();

    localparam int MAX_STEPS  = 40;
    localparam int RST_CYCLES = 8;
    localparam int SEED       = 32'h10d6_b320;

    logic      clk;
    logic      rst_n;
    logic      if_en;
    word_t     if_insn;
    logic      stall;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      if_stall;
    logic      ex_en;
    word_t     ex_out;
    reg_addr_t ex_dst_addr;
    logic      ex_gpr_we;
    mem_op_t   ex_mem_op;
    word_t     ex_mem_wr_data;
    logic      branch_taken;
    word_t     branch_target;

    // ------------------------------
    // stimulus table
    // ------------------------------
    logic [127:0] tab_name     [MAX_STEPS];
    logic         tab_en       [MAX_STEPS];
    word_t        tab_insn     [MAX_STEPS];
    logic         tab_stall    [MAX_STEPS];
    logic         tab_wb_we    [MAX_STEPS];
    reg_addr_t    tab_wb_addr  [MAX_STEPS];
    word_t        tab_wb_data  [MAX_STEPS];
    logic         tab_exp_en   [MAX_STEPS];
    word_t        tab_exp_out  [MAX_STEPS];
    reg_addr_t    tab_exp_dst  [MAX_STEPS];
    logic         tab_exp_we   [MAX_STEPS];
    mem_op_t      tab_exp_mem  [MAX_STEPS];
    word_t        tab_exp_wdat [MAX_STEPS];  // store data
    logic         tab_exp_br   [MAX_STEPS];
    logic         tab_exp_ifs  [MAX_STEPS];

    int    num_steps;
    int    cur;         // row currently driven
    logic  live;
    logic  first;       // first cycle of that row
    int    cycle_cnt;
    int    max_cycles;
    int    err_cnt;
    word_t r1_val, r2_val, r18_val, slt_val;

    cpu_id_ex cpu_id_ex_i (.*);

    bind cpu_id_ex cpu_id_ex_props props_i (.*);

    id_ex_checker check_i (
        .clk, .rst_n, .live, .first, .stall,
        .name(tab_name[cur]), .exp_en(tab_exp_en[cur]), .exp_out(tab_exp_out[cur]),
        .exp_dst(tab_exp_dst[cur]), .exp_we(tab_exp_we[cur]), .exp_mem(tab_exp_mem[cur]),
        .exp_wdat(tab_exp_wdat[cur]), .exp_br(tab_exp_br[cur]), .exp_ifs(tab_exp_ifs[cur]),
        .if_stall, .ex_en, .ex_out, .ex_dst_addr, .ex_gpr_we, .ex_mem_op, .ex_mem_wr_data,
        .branch_taken, .branch_target, .err_cnt
    );

    always #5 clk = ~clk;

    function automatic word_t encode_r(input logic [5:0] op, input int ra, input int rb,
                                       input int rd);
        return {op, ra[4:0], rb[4:0], rd[4:0], 11'd0};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input int ra, input int rb,
                                       input logic [15:0] imm);
        return {op, ra[4:0], rb[4:0], imm};
    endfunction

    task automatic add_insn_step(input logic [127:0] tname, input word_t insn, input logic stl,
                                 input logic en, input word_t out, input reg_addr_t dst,
                                 input logic we, input mem_op_t mem, input logic br,
                                 input logic ifs);
        tab_name[num_steps]     = tname;
        tab_en[num_steps]       = (insn != '0);  // an all-zero word is an idle slot
        tab_insn[num_steps]     = insn;
        tab_stall[num_steps]    = stl;
        tab_wb_we[num_steps]    = 1'b0;
        tab_wb_addr[num_steps]  = '0;
        tab_wb_data[num_steps]  = '0;
        tab_exp_en[num_steps]   = en;
        tab_exp_out[num_steps]  = out;
        tab_exp_dst[num_steps]  = dst;
        tab_exp_we[num_steps]   = we;
        tab_exp_mem[num_steps]  = mem;
        tab_exp_wdat[num_steps] = '0;
        tab_exp_br[num_steps]   = br;
        tab_exp_ifs[num_steps]  = ifs;
        num_steps++;
    endtask

    // writeback only, execute sees an idle slot
    task automatic add_preload_step(input logic [127:0] tname, input reg_addr_t addr,
                                    input word_t data);
        add_insn_step(tname, '0, 1'b0, 1'b0, '0, '0, 1'b0, MEM_NOP, 1'b0, 1'b0);
        tab_wb_we[num_steps-1]   = 1'b1;
        tab_wb_addr[num_steps-1] = addr;
        tab_wb_data[num_steps-1] = data;
    endtask

    task automatic build_table();
        r1_val  = $urandom;
        r2_val  = $urandom;
        if (r2_val == r1_val) begin
            r2_val = ~r1_val;  // keeps bne taken
        end
        r18_val = $urandom;
        slt_val = ($signed(r1_val) < $signed(r2_val)) ? 32'd1 : 32'd0;
        num_steps = 0;
        add_preload_step("wb_r1", 1, r1_val);
        add_preload_step("wb_r2", 2, r2_val);
        add_preload_step("wb_r0", 0, 32'hdead_beef);
        add_preload_step("wb_r18", 18, r18_val);
        add_insn_step("add", encode_r(OP_ADD, 1, 2, 5), 0, 1, r1_val + r2_val, 5, 1, MEM_NOP, 0, 0);
        add_insn_step("sub", encode_r(OP_SUB, 1, 2, 6), 0, 1, r1_val - r2_val, 6, 1, MEM_NOP, 0, 0);
        add_insn_step("and", encode_r(OP_AND, 1, 2, 7), 0, 1, r1_val & r2_val, 7, 1, MEM_NOP, 0, 0);
        add_insn_step("or", encode_r(OP_OR, 1, 2, 8), 0, 1, r1_val | r2_val, 8, 1, MEM_NOP, 0, 0);
        add_insn_step("xor", encode_r(OP_XOR, 1, 2, 9), 0, 1, r1_val ^ r2_val, 9, 1, MEM_NOP, 0, 0);
        add_insn_step("slt", encode_r(OP_SLT, 1, 2, 10), 0, 1, slt_val, 10, 1, MEM_NOP, 0, 0);
        add_insn_step("addi", encode_i(OP_ADDI, 1, 11, 16'hfff0), 0, 1,
                      r1_val + 32'hffff_fff0, 11, 1, MEM_NOP, 0, 0);
        add_insn_step("ori", encode_i(OP_ORI, 2, 12, 16'h8001), 0, 1,
                      r2_val | 32'h0000_8001, 12, 1, MEM_NOP, 0, 0);
        add_insn_step("lui", encode_i(OP_LUI, 0, 13, 16'h1234), 0, 1,
                      32'h1234_0000, 13, 1, MEM_NOP, 0, 0);
        // back-to-back dependencies
        add_insn_step("fwd_a", encode_r(OP_ADD, 13, 1, 14), 0, 1,
                      32'h1234_0000 + r1_val, 14, 1, MEM_NOP, 0, 0);
        add_insn_step("fwd_b", encode_r(OP_SUB, 1, 14, 15), 0, 1,
                      r1_val - (32'h1234_0000 + r1_val), 15, 1, MEM_NOP, 0, 0);
        add_insn_step("r0_dst", encode_r(OP_ADD, 1, 2, 0), 0, 1, r1_val + r2_val, 0, 1, MEM_NOP, 0, 0);
        add_insn_step("r0_read", encode_r(OP_ADD, 0, 2, 16), 0, 1, r2_val, 16, 1, MEM_NOP, 0, 0);
        add_insn_step("unknown", encode_r(6'h3f, 1, 2, 17), 0, 1, '0, 17, 0, MEM_NOP, 0, 0);
        // load-use, then store
        add_insn_step("ld", encode_i(OP_LD, 1, 18, 16'h0010), 0, 1,
                      r1_val + 32'h10, 18, 1, MEM_LD, 0, 0);
        add_insn_step("ld_use", encode_r(OP_ADD, 18, 2, 19), 0, 1,
                      r18_val + r2_val, 19, 1, MEM_NOP, 0, 1);
        add_insn_step("st", encode_i(OP_ST, 1, 2, 16'hfffc), 0, 1,
                      r1_val + 32'hffff_fffc, 2, 0, MEM_ST, 0, 0);
        tab_exp_wdat[num_steps-1] = r2_val;
        // branches
        add_insn_step("beq_taken", encode_i(OP_BEQ, 1, 1, 16'h0040), 0, 1,
                      32'h40, 0, 0, MEM_NOP, 1, 0);
        add_insn_step("beq_squash", encode_r(OP_ADD, 1, 2, 20), 0, 0, '0, 0, 0, MEM_NOP, 0, 0);
        add_insn_step("bne_not_taken", encode_i(OP_BNE, 1, 1, 16'h0080), 0, 1,
                      32'h80, 0, 0, MEM_NOP, 0, 0);
        add_insn_step("after_bne", encode_r(OP_ADD, 1, 2, 21), 0, 1,
                      r1_val + r2_val, 21, 1, MEM_NOP, 0, 0);
        add_insn_step("bne_taken", encode_i(OP_BNE, 1, 2, 16'h0100), 0, 1,
                      32'h100, 0, 0, MEM_NOP, 1, 0);
        add_insn_step("bne_squash", encode_r(OP_XOR, 1, 2, 22), 0, 0, '0, 0, 0, MEM_NOP, 0, 0);
        // external stall holds execute
        add_insn_step("pre_stall", encode_r(OP_OR, 1, 2, 23), 0, 1,
                      r1_val | r2_val, 23, 1, MEM_NOP, 0, 0);
        add_insn_step("stall_1", encode_r(OP_AND, 1, 2, 24), 1, 1,
                      r1_val | r2_val, 23, 1, MEM_NOP, 0, 1);
        add_insn_step("stall_2", encode_r(OP_AND, 1, 2, 24), 1, 1,
                      r1_val | r2_val, 23, 1, MEM_NOP, 0, 1);
        add_insn_step("after_stall", encode_r(OP_AND, 1, 2, 24), 0, 1,
                      r1_val & r2_val, 24, 1, MEM_NOP, 0, 0);
    endtask

    // ------------------------------
    // timeout
    // ------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int i;
        int applied;
        void'($urandom(SEED));
        clk     = 1'b0;
        rst_n   = 1'b0;
        if_en   = 1'b0;
        if_insn = '0;
        stall   = 1'b0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        live    = 1'b0;
        first   = 1'b0;
        cur     = 0;
        cycle_cnt = 0;
        build_table();
        max_cycles = 2 * num_steps + RST_CYCLES + 20;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        i       = 0;
        applied = -1;
        while (i < num_steps) begin
            @(posedge clk);
            cur     <= i;
            live    <= 1'b1;
            first   <= (i != applied);
            if_en   <= tab_en[i];
            if_insn <= tab_insn[i];
            stall   <= tab_stall[i];
            wb_we   <= tab_wb_we[i];
            wb_addr <= tab_wb_addr[i];
            wb_data <= tab_wb_data[i];
            applied = i;
            @(negedge clk);
            if (!(if_stall && !tab_stall[i])) begin  // fetch holds on a hazard
                i++;
            end
        end
        @(posedge clk);
        live  <= 1'b0;
        if_en <= 1'b0;
        stall <= 1'b0;
        wb_we <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d checker, %0d assertion", err_cnt, cpu_id_ex_i.props_i.fail_cnt);
        if (err_cnt == 0 && cpu_id_ex_i.props_i.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/cpu_pkg.sv
logic/gpr_file.sv
logic/id_decoder.sv
logic/pipe_ctrl.sv
logic/id_reg.sv
logic/ex_stage.sv
logic/cpu_id_ex.sv
testbench/id_ex_checker.sv
testbench/cpu_id_ex_props.sv
testbench/tb_cpu_id_ex.sv

// ==== Bender.yml ====
package:
  name: cpu_id_ex

sources:
  - logic/cpu_pkg.sv
  - logic/gpr_file.sv
  - logic/id_decoder.sv
  - logic/pipe_ctrl.sv
  - logic/id_reg.sv
  - logic/ex_stage.sv
  - logic/cpu_id_ex.sv
  - target: test
    files:
      - testbench/id_ex_checker.sv
      - testbench/cpu_id_ex_props.sv
      - testbench/tb_cpu_id_ex.sv
